//--- Makefile
# Verilator build and run for the debug module testbench

VERILATOR ?= verilator
TOP       ?= dbg_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
FAIL_MSG  ?= tests failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test build clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fail if the log reports failure"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation FAILED"; exit 1; \
	else \
	  echo "simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- compile.f
+incdir+source
source/dbg_pkg.sv
source/dbg_crc32.sv
source/dbg_bus_unit.sv
source/dbg_status_reg.sv
source/dbg_burst_fsm.sv
source/dbg_cpu_module.sv
dv/dbg_properties.sv
dv/dbg_tb.sv

//--- dv/dbg_patterns.txt
# name op addr count flag w0 w1 w2 w3 (all hex except name)
# op 3 write (flag is match bit), 7 read, 9 stall write, 0 breakpoint pulse
wr_burst4 3 10 4 1 deadbeef 12345678 a5a5a5a5 0f0f0f0f
rd_burst4 7 10 4 1 deadbeef 12345678 a5a5a5a5 0f0f0f0f
wr_burst2 3 20 2 1 cafef00d 80000001 0 0
rd_burst2 7 20 2 1 cafef00d 80000001 0 0
wr_badcrc 3 30 1 0 13579bdf 0 0 0
rd_badcrc 7 30 1 1 13579bdf 0 0 0
rd_fill 7 28 2 1 5a002828 5a002929 0 0
stall_set 9 0 0 1 0 0 0 0
stall_clr 9 0 0 0 0 0 0 0
bp_pulse 0 0 0 1 0 0 0 0
stall_clr2 9 0 0 0 0 0 0 0

//--- dv/dbg_properties.sv
/* Bus protocol checks for the debug bus unit
   Bound into the bus unit, reports through failing assertions */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_macros.svh"

module dbg_properties (
  input logic                   tck_i,
  input logic                   tlr_i,
  input logic                   cpu_stb_o,
  input logic                   cpu_we_o,
  input logic                   cpu_ack_i,
  input logic [`DBG_WORD_W-1:0] cpu_addr_o,
  input logic [`DBG_WORD_W-1:0] cpu_data_o
);

  // Strobe holds until the slave acks
  stb_hold_a : assert property (@(posedge tck_i) disable iff (tlr_i)
    cpu_stb_o && !cpu_ack_i |=> cpu_stb_o)
    else $error("bus strobe dropped before ack");

  // Request is frozen for the whole bus cycle
  req_stable_a : assert property (@(posedge tck_i) disable iff (tlr_i)
    cpu_stb_o && !cpu_ack_i |=> $stable(cpu_addr_o) && $stable(cpu_we_o) &&
                                 $stable(cpu_data_o))
    else $error("bus address, data or we changed while strobe was high");

  reset_idle_a : assert property (@(posedge tck_i)
    tlr_i |-> !cpu_stb_o && !cpu_we_o)
    else $error("bus strobe or we high during reset");

endmodule

`default_nettype wire

//--- dv/dbg_tb.sv
/* Debug module testbench
   TAP driver, DR model, CPU memory model and pattern driven checks */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_macros.svh"

module dbg_tb;

  logic        tck_i = 1'b0;
  logic        tlr_i = 1'b1;
  logic        tdi_i = 1'b0;
  logic        capture_dr_i = 1'b0;
  logic        shift_dr_i = 1'b0;
  logic        update_dr_i = 1'b0;
  logic        module_select_i = 1'b1;  // Module always selected
  logic [63:0] data_register_i = '0;    // DR model that shifts in at bit 63
  logic [31:0] cpu_data_i = '0;
  logic        cpu_ack_i = 1'b0;
  logic        cpu_bp_i = 1'b0;
  logic        module_tdo_o, top_inhibit_o, cpu_stb_o, cpu_we_o, cpu_stall_o;
  logic [31:0] cpu_addr_o, cpu_data_o;
  logic [31:0] mem [0:63];              // CPU memory
  string       names[$];
  logic [31:0] ops[$], addrs[$], counts[$], flags[$], words[$];
  int          total_words = 0;
  int          errors = 0;
  int          checks = 0;
  bit          loaded = 1'b0;

  dbg_cpu_module dut0 (.*);

  bind dbg_bus_unit dbg_properties u_props (.*);

  always #20 tck_i = ~tck_i;  // 40 ns period

  //////////////////////
  // CPU memory that acks after 1 to 4 cycles
  initial begin
    int n;
    void'($urandom(32'hf88d7d55));  // Ack latency seed
    for (int i = 0; i < 64; i++) mem[i] = 32'h5a000000 | (i << 8) | i;
    forever begin
      @(posedge tck_i);
      #5;
      if (cpu_stb_o) begin
        n = 1 + $urandom % 4;
        repeat (n - 1) begin
          @(posedge tck_i);
          #5;
        end
        cpu_ack_i = 1'b1;
        if (cpu_we_o) mem[cpu_addr_o[5:0]] = cpu_data_o;
        else cpu_data_i = mem[cpu_addr_o[5:0]];
        @(posedge tck_i);
        #5 cpu_ack_i = 1'b0;
      end
    end
  end

  // Watchdog sized from the pattern words
  initial begin
    wait (loaded);
    repeat (total_words * 80 + 2000) @(posedge tck_i);
    $display("timeout: the run did not finish in time");
    $display("tests failed");
    $finish;
  end

  // Reflected CRC-32 step over one data bit
  function automatic logic [31:0] crc_step(logic [31:0] crc, logic b);
    logic fb;
    fb = crc[0] ^ b;
    return (crc >> 1) ^ (fb ? `DBG_CRC_POLY : 32'h0);
  endfunction

  function automatic logic [63:0] make_cmd(logic [3:0] op, logic [31:0] a,
                                           logic [15:0] n, logic stall);
    logic [63:0] c;
    c = '0;  // Bit 63 low marks a command for this module
    c[62:59] = op;
    if (op == 4'h9) c[57] = stall;
    else begin
      c[58:27] = a;
      c[26:11] = n;
    end
    return c;
  endfunction

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("error %s: expected %h actual %h", name, exp, act);
    end
  endtask

  // One TCK cycle that applies the last DR shift, drives, then samples mid cycle
  task automatic tap_cycle(input logic cap, input logic sh, input logic upd,
                           input logic din, output logic tdo, output logic inh);
    @(posedge tck_i);
    #5;
    if (shift_dr_i) data_register_i = {tdi_i, data_register_i[63:1]};
    capture_dr_i = cap;
    shift_dr_i   = sh;
    update_dr_i  = upd;
    tdi_i        = din;
    #20;
    tdo = module_tdo_o;
    inh = top_inhibit_o;
  endtask

  task automatic load_cmd(logic [63:0] c);
    logic t, h;
    tap_cycle(0, 0, 0, 0, t, h);
    data_register_i = c;
    tap_cycle(0, 0, 1, 0, t, h);
  endtask

  //////////////////////
  // Burst write with CRC and match bit
  task automatic write_burst(int k, int base);
    logic [31:0] crc;
    logic t, h;
    crc = '1;
    load_cmd(make_cmd(ops[k][3:0], addrs[k], counts[k][15:0], 1'b0));
    tap_cycle(1, 0, 0, 0, t, h);
    tap_cycle(0, 1, 0, 1, t, h);  // Start bit
    check_val({names[k], " inhibit"}, 1, h);
    for (int w = 0; w < counts[k]; w++)
      for (int b = 0; b < 32; b++) begin
        tap_cycle(0, 1, 0, words[base + w][b], t, h);
        crc = crc_step(crc, words[base + w][b]);
      end
    if (flags[k] == 0) crc = crc ^ 32'h1;  // Corrupted CRC
    for (int b = 0; b < 32; b++) tap_cycle(0, 1, 0, crc[b], t, h);
    tap_cycle(0, 1, 0, 0, t, h);
    check_val({names[k], " match"}, flags[k], t);
    tap_cycle(0, 0, 1, 0, t, h);
    check_val({names[k], " inhibit match"}, 1, h);
    tap_cycle(0, 0, 0, 0, t, h);
    check_val({names[k], " inhibit idle"}, 0, h);
    repeat (8) tap_cycle(0, 0, 0, 0, t, h);  // Last bus write settles
    for (int w = 0; w < counts[k]; w++)
      check_val({names[k], " mem"}, words[base + w], mem[(addrs[k] + w) % 64]);
  endtask

  //////////////////////
  // Burst read of status bit, data and CRC
  task automatic read_burst(int k, int base);
    logic [31:0] crc, word, crc_rx;
    logic t, h;
    int tries;
    crc = '1;
    tries = 0;
    load_cmd(make_cmd(ops[k][3:0], addrs[k], counts[k][15:0], 1'b0));
    tap_cycle(0, 0, 0, 0, t, h);
    tap_cycle(1, 0, 0, 0, t, h);
    do begin
      tap_cycle(0, 1, 0, 0, t, h);
      tries++;
    end while (!t && tries < 200);
    checks++;
    assert (t) else begin
      errors++;
      $display("%s: read status bit never became 1", names[k]);
    end
    check_val({names[k], " inhibit"}, 1, h);
    for (int w = 0; w < counts[k]; w++) begin
      for (int b = 0; b < 32; b++) begin
        tap_cycle(0, 1, 0, 0, t, h);
        word[b] = t;  // LSB first
        crc = crc_step(crc, t);
      end
      check_val({names[k], " data"}, words[base + w], word);
    end
    for (int b = 0; b < 32; b++) begin
      tap_cycle(0, 1, 0, 0, t, h);
      crc_rx[b] = t;
    end
    check_val({names[k], " crc"}, crc, crc_rx);
    tap_cycle(0, 0, 1, 0, t, h);
    check_val({names[k], " inhibit crc"}, 1, h);
    tap_cycle(0, 0, 0, 0, t, h);
    check_val({names[k], " inhibit idle"}, 0, h);
  endtask

  // Stall write or breakpoint followed by readback in idle
  task automatic stall_readback(int k);
    logic t, h;
    if (ops[k] == 0) begin
      @(posedge tck_i);
      #5 cpu_bp_i = 1'b1;
      @(posedge tck_i);
      #5 cpu_bp_i = 1'b0;
    end else begin
      load_cmd(make_cmd(ops[k][3:0], '0, '0, flags[k][0]));
    end
    tap_cycle(0, 0, 0, 0, t, h);
    check_val({names[k], " stall"}, flags[k], cpu_stall_o);
    tap_cycle(1, 0, 0, 0, t, h);
    tap_cycle(0, 1, 0, 0, t, h);
    check_val({names[k], " readback"}, flags[k], t);
    tap_cycle(0, 0, 0, 0, t, h);
  endtask

  //////////////////////
  // Main sequence
  initial begin
    int fd, base;
    string line, nm;
    logic [31:0] op, a, n, f, w0, w1, w2, w3;
    fd = $fopen("dv/dbg_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file");
      $display("tests failed");
      $finish;
    end else begin
      while ($fgets(line, fd)) begin
        if (line.len() < 2 || line[0] == "#") continue;
        void'($sscanf(line, "%s %h %h %h %h %h %h %h %h", nm, op, a, n, f,
                      w0, w1, w2, w3));
        names.push_back(nm);
        ops.push_back(op);
        addrs.push_back(a);
        counts.push_back(n);
        flags.push_back(f);
        words.push_back(w0);
        words.push_back(w1);
        words.push_back(w2);
        words.push_back(w3);
        total_words += n;
      end
      $fclose(fd);
      loaded = 1'b1;
      repeat (2) @(posedge tck_i);
      #5 tlr_i = 1'b0;  // Reset held for 2 cycles
      for (int k = 0; k < names.size(); k++) begin
        base = k * 4;
        if (ops[k] == 3) write_burst(k, base);
        else if (ops[k] == 7) read_burst(k, base);
        else stall_readback(k);
      end
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
        $display("all tests passed");
      end else begin
        $display("tests failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- source/dbg_burst_fsm.sv
/* Debug module control FSM
   Sequences burst reads and writes, holds address, word and bit counters */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_macros.svh"

module dbg_burst_fsm (
  input  logic                   tck_i,
  input  logic                   tlr_i,
  input  dbg_pkg::dbg_cmd_t      cmd_i,
  input  logic                   dr_msb_i,      // Write start bit
  input  logic                   capture_dr_i,
  input  logic                   shift_dr_i,
  input  logic                   update_dr_i,
  input  logic                   module_select_i,
  input  logic                   biu_rdy_i,
  output logic [`DBG_WORD_W-1:0] addr_o,
  output logic                   rd_wrn_o,
  output logic                   biu_strobe_o,
  output logic                   out_ld_o,
  output logic                   out_src_bus_o,  // 1 loads bus data, 0 status
  output logic                   out_shift_o,
  output logic                   crc_clr_o,
  output logic                   crc_en_o,
  output logic                   crc_in_tdi_o,   // 1 for write data
  output logic                   crc_shift_o,
  output dbg_pkg::dbg_tdo_sel_e  tdo_sel_o,
  output logic                   status_we_o,
  output logic                   top_inhibit_o
);

  dbg_pkg::dbg_state_e     state_q;
  dbg_pkg::dbg_state_e     state_d;
  dbg_pkg::dbg_opcode_e    op_q;        // Latched burst opcode
  logic [`DBG_WORD_W-1:0]  addr_q;
  logic [`DBG_COUNT_W-1:0] word_cnt_q;  // Words left
  logic [5:0]              bit_cnt_q;
  logic addr_ld;
  logic addr_inc;
  logic word_ld;
  logic word_dec;
  logic bit_rst;
  logic bit_inc;
  logic op_ld;
  logic word_zero;
  logic word_last;
  logic bit_max;
  logic bit_32;
  logic cmd_hit;
  logic burst_cmd;

  assign word_zero = (word_cnt_q == '0);
  assign word_last = (word_cnt_q == `DBG_COUNT_W'(1));  // No further prefetch
  assign bit_max   = (bit_cnt_q == 6'(`DBG_WORD_W - 1));
  assign bit_32    = (bit_cnt_q == 6'(`DBG_WORD_W));      // CRC fully shifted in
  assign cmd_hit   = module_select_i & cmd_i.module_cmd & update_dr_i;
  assign burst_cmd = (cmd_i.opcode == dbg_pkg::op_bwrite32) |
                     (cmd_i.opcode == dbg_pkg::op_bread32);

  //////////////////////
  // Next state and controls
  always_comb begin
    state_d       = state_q;
    {addr_ld, addr_inc, word_ld, word_dec, bit_rst, bit_inc, op_ld} = '0;
    biu_strobe_o  = 1'b0;
    out_ld_o      = 1'b0;
    out_src_bus_o = 1'b0;
    out_shift_o   = 1'b0;
    crc_clr_o     = 1'b0;
    crc_en_o      = 1'b0;
    crc_in_tdi_o  = 1'b0;
    crc_shift_o   = 1'b0;
    status_we_o   = 1'b0;
    top_inhibit_o = 1'b0;
    tdo_sel_o     = dbg_pkg::tdo_data_out;
    case (state_q)
      dbg_pkg::st_idle: begin
        out_ld_o    = module_select_i & capture_dr_i;  // Status readback
        out_shift_o = module_select_i & shift_dr_i;
        status_we_o = cmd_hit & (cmd_i.opcode == dbg_pkg::op_ireg_wr) &
                      (cmd_i.reg_select == '0);
        if (cmd_hit && burst_cmd) begin
          {addr_ld, op_ld, word_ld, bit_rst, crc_clr_o} = '1;
          state_d = cmd_i.opcode[2] ? dbg_pkg::st_rbegin : dbg_pkg::st_wready;
        end
      end
      dbg_pkg::st_rbegin: begin
        if (word_zero) begin
          state_d = dbg_pkg::st_idle;  // Empty burst
        end else begin
          biu_strobe_o = 1'b1;         // Fetch first word early
          addr_inc     = 1'b1;
          state_d      = dbg_pkg::st_rready;
        end
      end
      dbg_pkg::st_rready: begin
        if (module_select_i && capture_dr_i) state_d = dbg_pkg::st_rstatus;
      end
      dbg_pkg::st_rstatus: begin
        tdo_sel_o     = dbg_pkg::tdo_biu_ready;
        top_inhibit_o = 1'b1;
        if (shift_dr_i && biu_rdy_i) begin
          {out_ld_o, out_src_bus_o, bit_rst, word_dec} = '1;
          biu_strobe_o = ~word_last;  // Prefetch next word
          addr_inc     = ~word_last;
          state_d      = dbg_pkg::st_rburst;
        end
      end
      dbg_pkg::st_rburst: begin
        top_inhibit_o = 1'b1;
        if (shift_dr_i) begin
          {out_shift_o, crc_en_o, bit_inc} = '1;  // CRC over TDO bits
          if (bit_max) begin
            bit_rst = 1'b1;
            if (word_zero) begin
              state_d = dbg_pkg::st_rcrc;
            end else begin
              {out_ld_o, out_src_bus_o, word_dec} = '1;  // Next word, no status bit
              biu_strobe_o = ~word_last;
              addr_inc     = ~word_last;
            end
          end
        end
      end
      dbg_pkg::st_rcrc: begin
        tdo_sel_o     = dbg_pkg::tdo_crc_out;
        crc_shift_o   = shift_dr_i;
        top_inhibit_o = 1'b1;
      end
      dbg_pkg::st_wready: begin
        if (word_zero) state_d = dbg_pkg::st_idle;
        else if (module_select_i && capture_dr_i) state_d = dbg_pkg::st_wwait;
      end
      dbg_pkg::st_wwait: begin
        top_inhibit_o = 1'b1;
        crc_in_tdi_o  = 1'b1;
        // Start bit is in the DR, tdi already carries data bit 0
        if (shift_dr_i && module_select_i && dr_msb_i) begin
          {bit_inc, word_dec, crc_en_o} = '1;
          state_d = dbg_pkg::st_wburst;
        end
      end
      dbg_pkg::st_wburst: begin
        top_inhibit_o = 1'b1;
        crc_in_tdi_o  = 1'b1;
        if (shift_dr_i) begin
          {crc_en_o, bit_inc} = '1;
          if (bit_max) begin
            {bit_rst, biu_strobe_o, addr_inc} = '1;  // Full word in DR
            if (word_zero) state_d = dbg_pkg::st_wcrc;
            else word_dec = 1'b1;
          end
        end
      end
      dbg_pkg::st_wcrc: begin
        top_inhibit_o = 1'b1;
        bit_inc       = shift_dr_i;
        if (bit_32) begin
          tdo_sel_o = dbg_pkg::tdo_crc_match;  // Match bit goes out now
          state_d   = dbg_pkg::st_wmatch;
        end
      end
      dbg_pkg::st_wmatch: begin
        tdo_sel_o     = dbg_pkg::tdo_crc_match;
        top_inhibit_o = 1'b1;
      end
      default: state_d = dbg_pkg::st_idle;
    endcase
    if (update_dr_i && state_q != dbg_pkg::st_idle) state_d = dbg_pkg::st_idle;  // Abort
  end

  //////////////////////
  // State and counters
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      state_q    <= dbg_pkg::st_idle;
      op_q       <= dbg_pkg::op_bwrite32;
      addr_q     <= '0;
      word_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else begin
      state_q <= state_d;
      if (op_ld) op_q <= cmd_i.opcode;
      if (addr_ld) addr_q <= cmd_i.address;
      else if (addr_inc) addr_q <= addr_q + 1'b1;  // Word addressed
      if (word_ld) word_cnt_q <= cmd_i.count;
      else if (word_dec) word_cnt_q <= word_cnt_q - 1'b1;
      if (bit_rst) bit_cnt_q <= '0;
      else if (bit_inc) bit_cnt_q <= bit_cnt_q + 1'b1;
    end
  end

  assign addr_o   = addr_q;
  assign rd_wrn_o = op_q[2];

endmodule

`default_nettype wire

//--- source/dbg_bus_unit.sv
/* CPU bus master for the debug module
   Latches one request per strobe, runs stb until ack, reports ready */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_macros.svh"

module dbg_bus_unit (
  input  logic                   tck_i,
  input  logic                   tlr_i,
  input  logic                   strobe_i,   // Start a bus cycle
  input  dbg_pkg::dbg_bus_req_t  req_i,
  output logic                   rdy_o,      // Low while a cycle is pending
  output logic [`DBG_WORD_W-1:0] rdata_o,
  output logic [`DBG_WORD_W-1:0] cpu_addr_o,
  output logic [`DBG_WORD_W-1:0] cpu_data_o,
  input  logic [`DBG_WORD_W-1:0] cpu_data_i,
  output logic                   cpu_stb_o,
  output logic                   cpu_we_o,
  input  logic                   cpu_ack_i
);

  dbg_pkg::dbg_bus_req_t  req_q;  // Held for the whole bus cycle
  logic [`DBG_WORD_W-1:0] rdata_q;
  logic                   rdy_q;
  logic                   stb_q;
  logic                   we_q;

  //////////////////////
  // Payload
  always_ff @(posedge tck_i) begin
    if (strobe_i) begin
      req_q <= req_i;
    end
    if (stb_q && cpu_ack_i && req_q.rd_wrn) begin
      rdata_q <= cpu_data_i;  // Capture read word on ack
    end
  end

  //////////////////////
  // Handshake
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      rdy_q <= 1'b1;
      stb_q <= 1'b0;
      we_q  <= 1'b0;
    end else if (strobe_i) begin
      rdy_q <= 1'b0;                 // Busy until ack
    end else if (!rdy_q && !stb_q) begin
      stb_q <= 1'b1;                 // Edge after strobe
      we_q  <= ~req_q.rd_wrn;
    end else if (stb_q && cpu_ack_i) begin
      stb_q <= 1'b0;
      we_q  <= 1'b0;
      rdy_q <= 1'b1;                 // Same edge as stb drop
    end
  end

  assign rdy_o      = rdy_q;
  assign rdata_o    = rdata_q;
  assign cpu_addr_o = req_q.addr;
  assign cpu_data_o = req_q.wdata;
  assign cpu_stb_o  = stb_q;
  assign cpu_we_o   = we_q;

endmodule

`default_nettype wire

//--- source/dbg_cpu_module.sv
/* JTAG debug module for one CPU
   Command decode, output shift register, TDO mux and CRC compare */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_macros.svh"

module dbg_cpu_module (
  input  logic                   tck_i,
  input  logic                   tlr_i,
  input  logic                   tdi_i,
  input  logic                   capture_dr_i,
  input  logic                   shift_dr_i,
  input  logic                   update_dr_i,
  input  logic                   module_select_i,
  input  logic [`DBG_DR_LEN-1:0] data_register_i,
  output logic                   module_tdo_o,
  output logic                   top_inhibit_o,
  output logic [`DBG_WORD_W-1:0] cpu_addr_o,
  output logic [`DBG_WORD_W-1:0] cpu_data_o,
  input  logic [`DBG_WORD_W-1:0] cpu_data_i,
  output logic                   cpu_stb_o,
  output logic                   cpu_we_o,
  input  logic                   cpu_ack_i,
  input  logic                   cpu_bp_i,
  output logic                   cpu_stall_o
);

  dbg_pkg::dbg_cmd_t      cmd;
  dbg_pkg::dbg_bus_req_t  bus_req;
  dbg_pkg::dbg_tdo_sel_e  tdo_sel;
  logic [`DBG_WORD_W-1:0] fsm_addr;
  logic [`DBG_WORD_W-1:0] biu_rdata;
  logic [`DBG_WORD_W-1:0] crc_val;
  logic [`DBG_WORD_W-1:0] out_q;  // Output shift register
  logic rd_wrn;
  logic biu_strobe;
  logic biu_rdy;
  logic out_ld;
  logic out_src_bus;
  logic out_shift;
  logic crc_clr;
  logic crc_en;
  logic crc_in_tdi;
  logic crc_shift;
  logic crc_serial;
  logic crc_bit;
  logic crc_match;
  logic status_we;

  //////////////////////
  // Command decode
  always_comb begin
    cmd.module_cmd = ~data_register_i[`DBG_TOP_BIT];
    cmd.opcode     = dbg_pkg::dbg_opcode_e'(data_register_i[`DBG_OP_MSB -: `DBG_OP_W]);
    cmd.address    = data_register_i[`DBG_ADDR_MSB -: `DBG_WORD_W];
    cmd.count      = data_register_i[`DBG_COUNT_MSB -: `DBG_COUNT_W];
    cmd.reg_select = data_register_i[`DBG_REGSEL_MSB -: `DBG_REGSEL_W];
    cmd.stall      = data_register_i[`DBG_STALL_BIT];
  end

  // Last write bit is still on TDI, the rest sits in the DR top
  assign bus_req.addr   = fsm_addr;
  assign bus_req.wdata  = {tdi_i, data_register_i[`DBG_DR_LEN-1 -: `DBG_WORD_W-1]};
  assign bus_req.rd_wrn = rd_wrn;

  //////////////////////
  // Output shift register and TDO
  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      out_q <= '0;
    end else if (out_ld) begin
      out_q <= out_src_bus ? biu_rdata : {{(`DBG_WORD_W-1){1'b0}}, cpu_stall_o};
    end else if (out_shift) begin
      out_q <= {1'b0, out_q[`DBG_WORD_W-1:1]};  // LSB first
    end
  end

  always_comb begin
    case (tdo_sel)
      dbg_pkg::tdo_biu_ready: module_tdo_o = biu_rdy;
      dbg_pkg::tdo_data_out:  module_tdo_o = out_q[0];
      dbg_pkg::tdo_crc_match: module_tdo_o = crc_match;
      default:                module_tdo_o = crc_serial;
    endcase
  end

  assign crc_bit   = crc_in_tdi ? tdi_i : out_q[0];  // Write data or read data
  assign crc_match = (data_register_i[`DBG_DR_LEN-1 -: `DBG_WORD_W] == crc_val);

  //////////////////////
  // Units
  dbg_burst_fsm u_fsm (
    .tck_i          (tck_i),
    .tlr_i          (tlr_i),
    .cmd_i          (cmd),
    .dr_msb_i       (data_register_i[`DBG_TOP_BIT]),
    .capture_dr_i   (capture_dr_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .module_select_i(module_select_i),
    .biu_rdy_i      (biu_rdy),
    .addr_o         (fsm_addr),
    .rd_wrn_o       (rd_wrn),
    .biu_strobe_o   (biu_strobe),
    .out_ld_o       (out_ld),
    .out_src_bus_o  (out_src_bus),
    .out_shift_o    (out_shift),
    .crc_clr_o      (crc_clr),
    .crc_en_o       (crc_en),
    .crc_in_tdi_o   (crc_in_tdi),
    .crc_shift_o    (crc_shift),
    .tdo_sel_o      (tdo_sel),
    .status_we_o    (status_we),
    .top_inhibit_o  (top_inhibit_o)
  );

  dbg_bus_unit u_biu (
    .tck_i     (tck_i),
    .tlr_i     (tlr_i),
    .strobe_i  (biu_strobe),
    .req_i     (bus_req),
    .rdy_o     (biu_rdy),
    .rdata_o   (biu_rdata),
    .cpu_addr_o(cpu_addr_o),
    .cpu_data_o(cpu_data_o),
    .cpu_data_i(cpu_data_i),
    .cpu_stb_o (cpu_stb_o),
    .cpu_we_o  (cpu_we_o),
    .cpu_ack_i (cpu_ack_i)
  );

  dbg_crc32 u_crc (
    .tck_i   (tck_i),
    .tlr_i   (tlr_i),
    .bit_i   (crc_bit),
    .en_i    (crc_en),
    .shift_i (crc_shift),
    .clr_i   (crc_clr),
    .crc_o   (crc_val),
    .serial_o(crc_serial)
  );

  dbg_status_reg u_status (
    .tck_i      (tck_i),
    .tlr_i      (tlr_i),
    .we_i       (status_we),
    .stall_i    (cmd.stall),
    .cpu_bp_i   (cpu_bp_i),
    .cpu_stall_o(cpu_stall_o)
  );

endmodule

`default_nettype wire

//--- source/dbg_crc32.sv
/* Serial reflected CRC-32, init all ones, no final inversion
   The CRC register is also the serial output shift register */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_macros.svh"

module dbg_crc32 (
  input  logic                   tck_i,
  input  logic                   tlr_i,
  input  logic                   bit_i,     // Serial data in
  input  logic                   en_i,      // One CRC step
  input  logic                   shift_i,   // Shift CRC out
  input  logic                   clr_i,
  output logic [`DBG_WORD_W-1:0] crc_o,
  output logic                   serial_o
);

  logic [`DBG_WORD_W-1:0] crc_q;
  logic                   fb;  // Feedback bit

  assign fb = crc_q[0] ^ bit_i;

  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      crc_q <= '1;
    end else if (clr_i) begin
      crc_q <= '1;  // New burst
    end else if (en_i) begin
      crc_q <= (crc_q >> 1) ^ ({`DBG_WORD_W{fb}} & `DBG_CRC_POLY);
    end else if (shift_i) begin
      crc_q <= {1'b0, crc_q[`DBG_WORD_W-1:1]};  // LSB goes out first
    end
  end

  assign crc_o    = crc_q;
  assign serial_o = crc_q[0];

endmodule

`default_nettype wire

//--- source/dbg_macros.svh
/* Debug module constants
   DR command layout, bus widths and CRC polynomial */
`ifndef DBG_MACROS_SVH
`define DBG_MACROS_SVH

`define DBG_DR_LEN     64            // JTAG data register length
`define DBG_WORD_W     32            // CPU address and data width
`define DBG_COUNT_W    16            // Burst word count
`define DBG_REGSEL_W   1             // Internal register select
`define DBG_OP_W       4
`define DBG_CRC_POLY   32'hedb88320  // Reflected CRC-32

// Top bit of each DR field
`define DBG_TOP_BIT    63            // 0 means the command is ours
`define DBG_OP_MSB     62
`define DBG_ADDR_MSB   58
`define DBG_COUNT_MSB  26
`define DBG_REGSEL_MSB 58            // Internal register commands only
`define DBG_STALL_BIT  57

`endif

//--- source/dbg_pkg.sv
/* Debug module types
   FSM states, opcodes, TDO sources, command and bus request structs */
`default_nettype none
`include "dbg_macros.svh"

package dbg_pkg;

  // Control FSM states
  typedef enum logic [3:0] {
    st_idle, st_rbegin, st_rready, st_rstatus,
    st_rburst, st_rcrc, st_wready, st_wwait,
    st_wburst, st_wcrc, st_wmatch
  } dbg_state_e;

  typedef enum logic [`DBG_OP_W-1:0] {
    op_bwrite32 = 4'h3,
    op_bread32  = 4'h7,  // Bit 2 set marks a read
    op_ireg_wr  = 4'h9,
    op_ireg_sel = 4'hd
  } dbg_opcode_e;

  // Source of module_tdo_o
  typedef enum logic [1:0] {
    tdo_crc_out   = 2'd0,
    tdo_crc_match = 2'd1,
    tdo_data_out  = 2'd2,
    tdo_biu_ready = 2'd3
  } dbg_tdo_sel_e;

  typedef struct packed {
    logic                     module_cmd;  // Not a top level command
    dbg_opcode_e              opcode;
    logic [`DBG_WORD_W-1:0]   address;
    logic [`DBG_COUNT_W-1:0]  count;       // Words in burst
    logic [`DBG_REGSEL_W-1:0] reg_select;
    logic                     stall;
  } dbg_cmd_t;

  typedef struct packed {
    logic [`DBG_WORD_W-1:0] addr;
    logic [`DBG_WORD_W-1:0] wdata;
    logic                   rd_wrn;  // 1 for read
  } dbg_bus_req_t;

endpackage

`default_nettype wire

//--- source/dbg_status_reg.sv
/* Stall status register
   Written by command, set by CPU breakpoint */
`timescale 1ns/1ps
`default_nettype none

module dbg_status_reg (
  input  logic tck_i,
  input  logic tlr_i,
  input  logic we_i,
  input  logic stall_i,   // Value from ireg_wr command
  input  logic cpu_bp_i,  // Breakpoint hit
  output logic cpu_stall_o
);

  always_ff @(posedge tck_i or posedge tlr_i) begin
    if (tlr_i) begin
      cpu_stall_o <= 1'b0;
    end else if (cpu_bp_i) begin
      cpu_stall_o <= 1'b1;     // Breakpoint wins over write
    end else if (we_i) begin
      cpu_stall_o <= stall_i;
    end
  end

endmodule

`default_nettype wire
